/* hw/decoding_graph_defines.svh */
`ifndef DECODING_GRAPH_DEFINES_SVH
`define DECODING_GRAPH_DEFINES_SVH

// Graph dimensions
`define GRID_WIDTH_X 4     // Vertices per round
`define GRID_WIDTH_U 3     // Rounds held in the graph

// Edge growth
`define MAX_WEIGHT 2       // Same weight on every edge
`define LINK_BIT_WIDTH 2   // Holds 0 to MAX_WEIGHT

// Run configuration
`define GROW_CNT_WIDTH 3   // Grow cycles per run, 1 to 7

`endif

/* hw/decoding_graph_pkg.sv */
`include "decoding_graph_defines.svh"

package decoding_graph_pkg;

    // Global stage seen by every edge in the graph
    typedef enum logic [1:0] {
        STAGE_IDLE    = 2'd0,  // Measurements may shift in
        STAGE_GROW    = 2'd1,  // Edges grow toward their weight
        STAGE_READOUT = 2'd2,  // Grown edges shift out one round per cycle
        STAGE_DONE    = 2'd3   // Waiting for req to drop
    } stage_e;

    // One round of corrections
    // vertical[x] links vertex x to the round below (or the bottom boundary)
    // horizontal[0] and horizontal[X] are the left and right boundary edges
    typedef struct packed {
        logic [`GRID_WIDTH_X-1:0] vertical;
        logic [`GRID_WIDTH_X:0]   horizontal;
    } correction_word_t;

endpackage

/* hw/stage_controller.sv */
`timescale 1ns/10ps
`include "decoding_graph_defines.svh"

module stage_controller (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       req_i,
    input  logic [`GROW_CNT_WIDTH-1:0] grow_cycles_i,
    output logic                       ack_o,
    output logic                       busy_o,
    output decoding_graph_pkg::stage_e stage_o,
    output logic                       correction_valid_o
);
    import decoding_graph_pkg::*;

    localparam logic [`GROW_CNT_WIDTH-1:0] LAST_ROUND = `GRID_WIDTH_U - 1;

    stage_e                     stage_q;
    logic [`GROW_CNT_WIDTH-1:0] grow_cnt_q;  // Grow cycles for the current run
    logic [`GROW_CNT_WIDTH-1:0] cycle_q;     // Cycles spent in the current stage
    logic                       ack_q;
    logic                       busy_q;
    logic                       valid_q;

    assign stage_o            = stage_q;
    assign ack_o              = ack_q;
    assign busy_o             = busy_q;
    assign correction_valid_o = valid_q;

    // Run configuration, captured when a request is accepted
    always_ff @(posedge clk_i) begin
        if (stage_q == STAGE_IDLE && req_i) begin
            grow_cnt_q <= grow_cycles_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            stage_q <= STAGE_IDLE;
            cycle_q <= '0;
            ack_q   <= 1'b0;
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= (stage_q == STAGE_READOUT);  // Shift bits lag the stage by one
            case (stage_q)
                STAGE_IDLE: begin
                    if (req_i) begin
                        cycle_q <= '0;
                        busy_q  <= 1'b1;
                        stage_q <= STAGE_GROW;
                    end
                end
                STAGE_GROW: begin
                    if (cycle_q == grow_cnt_q - 1'b1) begin
                        cycle_q <= '0;
                        stage_q <= STAGE_READOUT;
                    end else begin
                        cycle_q <= cycle_q + 1'b1;
                    end
                end
                STAGE_READOUT: begin
                    if (cycle_q == LAST_ROUND) begin
                        stage_q <= STAGE_DONE;
                    end else begin
                        cycle_q <= cycle_q + 1'b1;
                    end
                end
                STAGE_DONE: begin
                    if (!req_i) begin  // Four-phase return to zero
                        ack_q   <= 1'b0;
                        busy_q  <= 1'b0;
                        stage_q <= STAGE_IDLE;
                    end else begin
                        ack_q <= 1'b1;
                    end
                end
                default: stage_q <= STAGE_IDLE;
            endcase
        end
    end

    // Acknowledge only answers a request that is still held
    assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_q) |-> $past(req_i))
        else $error("ack_o rose without req_i");

    assert property (@(posedge clk_i) disable iff (reset_i)
        (stage_q == STAGE_DONE) && req_i |=> (stage_q == STAGE_DONE))
        else $error("stage left DONE while req_i was high");

endmodule

/* hw/edge_link.sv */
`timescale 1ns/10ps
`include "decoding_graph_defines.svh"

module edge_link (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  decoding_graph_pkg::stage_e stage_i,
    input  logic                       a_increase_i,  // Endpoint a is a defect
    input  logic                       b_increase_i,  // Endpoint b is a defect
    input  logic                       shift_in_i,    // From the same edge one round up
    output logic                       fully_grown_o,
    output logic                       shift_out_o
);
    import decoding_graph_pkg::*;

    localparam logic [`LINK_BIT_WIDTH-1:0] MAX_W = `MAX_WEIGHT;

    logic [`LINK_BIT_WIDTH-1:0] growth_q;
    logic [`LINK_BIT_WIDTH:0]   growth_sum;  // One spare bit before saturation
    logic                       readout_q;   // Set after the first readout cycle
    logic                       shift_q;

    assign growth_sum    = {1'b0, growth_q} + a_increase_i + b_increase_i;
    assign fully_grown_o = (growth_q == MAX_W);
    assign shift_out_o   = shift_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            growth_q  <= '0;
            readout_q <= 1'b0;
        end else begin
            readout_q <= (stage_i == STAGE_READOUT);
            if (stage_i == STAGE_IDLE) begin
                growth_q <= '0;  // Every run starts from an empty graph
            end else if (stage_i == STAGE_GROW) begin
                if (growth_sum > MAX_W) begin
                    growth_q <= MAX_W;
                end else begin
                    growth_q <= growth_sum[`LINK_BIT_WIDTH-1:0];
                end
            end
        end
    end

    // Systolic readout path
    always_ff @(posedge clk_i) begin
        if (stage_i == STAGE_READOUT) begin
            if (readout_q) begin
                shift_q <= shift_in_i;     // Pass the round above downward
            end else begin
                shift_q <= fully_grown_o;  // First cycle takes this round's result
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        growth_q <= MAX_W)
        else $error("edge growth above MAX_WEIGHT");

endmodule

/* hw/graph_layer.sv */
`timescale 1ns/10ps
`include "decoding_graph_defines.svh"

module graph_layer (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  decoding_graph_pkg::stage_e           stage_i,
    input  logic                                 meas_valid_i,
    input  logic [`GRID_WIDTH_X-1:0]             meas_in_i,       // Layer above or new round
    input  logic [`GRID_WIDTH_X-1:0]             meas_below_i,    // Zero for the bottom layer
    output logic [`GRID_WIDTH_X-1:0]             meas_o,
    input  logic [`GRID_WIDTH_X-1:0]             defect_below_i,  // Zero for the bottom layer
    output logic [`GRID_WIDTH_X-1:0]             defect_o,
    input  decoding_graph_pkg::correction_word_t corr_in_i,
    output decoding_graph_pkg::correction_word_t corr_o
);
    import decoding_graph_pkg::*;

    localparam int X = `GRID_WIDTH_X;

    logic [X-1:0] meas_q;
    logic [X-1:0] defect;
    logic [X:0]   h_shift;  // Horizontal edge readout bits
    logic [X-1:0] v_shift;  // Vertical edge readout bits

    // Rounds only move while the graph is idle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            meas_q <= '0;
        end else if (stage_i == STAGE_IDLE && meas_valid_i) begin
            meas_q <= meas_in_i;
        end
    end

    assign meas_o   = meas_q;
    assign defect   = meas_q ^ meas_below_i;  // Syndrome change between rounds
    assign defect_o = defect;

    assign corr_o.horizontal = h_shift;
    assign corr_o.vertical   = v_shift;

    // Horizontal edges, with a boundary edge at each end of the line
    for (genvar h = 0; h <= X; h++) begin : g_horizontal
        logic a_defect;
        logic b_defect;

        if (h == 0) begin : g_left
            assign a_defect = defect[0];
            assign b_defect = 1'b0;  // Left boundary
        end else if (h == X) begin : g_right
            assign a_defect = defect[X-1];
            assign b_defect = 1'b0;  // Right boundary
        end else begin : g_inner
            assign a_defect = defect[h-1];
            assign b_defect = defect[h];
        end

        edge_link u_edge (
            .clk_i         (clk_i),
            .reset_i       (reset_i),
            .stage_i       (stage_i),
            .a_increase_i  (a_defect),
            .b_increase_i  (b_defect),
            .shift_in_i    (corr_in_i.horizontal[h]),
            .fully_grown_o (),
            .shift_out_o   (h_shift[h])
        );
    end

    // Vertical edges down to the layer below
    for (genvar x = 0; x < X; x++) begin : g_vertical
        edge_link u_edge (
            .clk_i         (clk_i),
            .reset_i       (reset_i),
            .stage_i       (stage_i),
            .a_increase_i  (defect[x]),
            .b_increase_i  (defect_below_i[x]),
            .shift_in_i    (corr_in_i.vertical[x]),
            .fully_grown_o (),
            .shift_out_o   (v_shift[x])
        );
    end

    // A run must see the same rounds from growth through readout
    assert property (@(posedge clk_i) disable iff (reset_i)
        (stage_i != STAGE_IDLE) |=> $stable(meas_q))
        else $error("measurements changed outside idle");

endmodule

/* hw/decoding_graph_top.sv */
`timescale 1ns/10ps
`include "decoding_graph_defines.svh"

module decoding_graph_top (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  logic                                 meas_valid_i,
    input  logic [`GRID_WIDTH_X-1:0]             measurements_i,
    input  logic                                 req_i,
    input  logic [`GROW_CNT_WIDTH-1:0]           grow_cycles_i,
    output logic                                 ack_o,
    output logic                                 busy_o,
    output logic                                 correction_valid_o,
    output decoding_graph_pkg::correction_word_t correction_o
);
    import decoding_graph_pkg::*;

    localparam int X = `GRID_WIDTH_X;
    localparam int U = `GRID_WIDTH_U;

    stage_e           stage;
    logic [X-1:0]     meas   [U];
    logic [X-1:0]     defect [U];
    correction_word_t corr   [U];

    stage_controller u_controller (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .req_i              (req_i),
        .grow_cycles_i      (grow_cycles_i),
        .ack_o              (ack_o),
        .busy_o             (busy_o),
        .stage_o            (stage),
        .correction_valid_o (correction_valid_o)
    );

    for (genvar k = 0; k < U; k++) begin : g_layer
        logic [X-1:0]     meas_in;
        logic [X-1:0]     meas_below;
        logic [X-1:0]     defect_below;
        correction_word_t corr_in;

        if (k == U - 1) begin : g_top
            assign meas_in = measurements_i;  // Newest round enters here
            assign corr_in = '0;
        end else begin : g_mid
            assign meas_in = meas[k+1];
            assign corr_in = corr[k+1];
        end

        if (k == 0) begin : g_bottom
            assign meas_below   = '0;  // Oldest round compares against zero
            assign defect_below = '0;  // Vertical edges end on the boundary
        end else begin : g_upper
            assign meas_below   = meas[k-1];
            assign defect_below = defect[k-1];
        end

        graph_layer u_layer (
            .clk_i          (clk_i),
            .reset_i        (reset_i),
            .stage_i        (stage),
            .meas_valid_i   (meas_valid_i),
            .meas_in_i      (meas_in),
            .meas_below_i   (meas_below),
            .meas_o         (meas[k]),
            .defect_below_i (defect_below),
            .defect_o       (defect[k]),
            .corr_in_i      (corr_in),
            .corr_o         (corr[k])
        );
    end

    assign correction_o = corr[0];  // Layer 0 first, then the rounds above

endmodule

/* tests/tb_decoding_graph.sv */
`timescale 1ns/10ps
`include "decoding_graph_defines.svh"

module tb_decoding_graph;
    import decoding_graph_pkg::*;

    localparam int X       = `GRID_WIDTH_X;
    localparam int U       = `GRID_WIDTH_U;
    localparam int GW      = `GROW_CNT_WIDTH;
    localparam int TIMEOUT = 64;  // Cycles allowed for any single wait

    logic             clk_i = 1'b0;
    logic             reset_i;
    logic             meas_valid_i;
    logic [X-1:0]     measurements_i;
    logic             req_i;
    logic [GW-1:0]    grow_cycles_i;
    logic             ack_o;
    logic             busy_o;
    logic             correction_valid_o;
    correction_word_t correction_o;

    logic [X-1:0] rounds [U];  // Model copy, index 0 holds the oldest round
    integer       seed = 51;
    int           errors = 0;
    int           errors_at_start = 0;
    int           test_count = 0;
    int           failed_tests = 0;
    bit           timed_out = 1'b0;

    always #4 clk_i = ~clk_i;

    decoding_graph_top uut (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .meas_valid_i       (meas_valid_i),
        .measurements_i     (measurements_i),
        .req_i              (req_i),
        .grow_cycles_i      (grow_cycles_i),
        .ack_o              (ack_o),
        .busy_o             (busy_o),
        .correction_valid_o (correction_valid_o),
        .correction_o       (correction_o)
    );

    // Handshake rules checked on every cycle
    assert property (@(posedge clk_i) disable iff (reset_i)
        correction_valid_o |-> busy_o && !ack_o)
        else begin
            errors++;
            $display("FAILED at %0t: correction word outside busy or during ack", $time);
        end

    assert property (@(posedge clk_i) disable iff (reset_i) ack_o |-> busy_o)
        else begin
            errors++;
            $display("FAILED at %0t: ack_o high while busy_o low", $time);
        end

    assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_o) |-> $past(correction_valid_o))
        else begin
            errors++;
            $display("FAILED at %0t: ack_o did not follow the last word", $time);
        end

    assert property (@(posedge clk_i) disable iff (reset_i) ack_o && req_i |=> ack_o)
        else begin
            errors++;
            $display("FAILED at %0t: ack_o dropped while req_i was high", $time);
        end

    assert property (@(posedge clk_i) disable iff (reset_i) $fell(ack_o) |-> $past(!req_i))
        else begin
            errors++;
            $display("FAILED at %0t: ack_o fell before req_i fell", $time);
        end

    // Growth min(MAX_WEIGHT, cycles x defective ends) reaches the weight
    function automatic logic grown(input int n, input int g);
        int growth;
        growth = n * g;
        if (growth > `MAX_WEIGHT) begin
            growth = `MAX_WEIGHT;
        end
        return growth == `MAX_WEIGHT;
    endfunction

    function automatic logic [X-1:0] defects_of(input int k);
        if (k == 0) begin
            return rounds[0];  // Bottom round compares against zero
        end
        return rounds[k] ^ rounds[k-1];
    endfunction

    function automatic correction_word_t expected_word(input int k, input int g);
        correction_word_t w;
        logic [X-1:0]     here;
        logic [X-1:0]     below;
        int               n;
        here  = defects_of(k);
        below = (k == 0) ? '0 : defects_of(k - 1);
        for (int h = 0; h <= X; h++) begin
            n = 0;
            if (h > 0 && here[h-1]) n++;
            if (h < X && here[h]) n++;
            w.horizontal[h] = grown(n, g);
        end
        for (int x = 0; x < X; x++) begin
            n = int'(here[x]) + int'(below[x]);
            w.vertical[x] = grown(n, g);
        end
        return w;
    endfunction

    task automatic finish_run();
        $display("tests: %0d, failed tests: %0d, errors: %0d", test_count, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s, simulation stopped", what);
        timed_out = 1'b1;
        finish_run();
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic load_round(input logic [X-1:0] w);
        @(posedge clk_i);
        meas_valid_i   <= 1'b1;
        measurements_i <= w;
        @(posedge clk_i);
        meas_valid_i <= 1'b0;
        for (int k = 0; k < U - 1; k++) begin
            rounds[k] = rounds[k+1];
        end
        rounds[U-1] = w;
    endtask

    // One four-phase decode run, words compared layer by layer
    task automatic run_decode(input int g, input int hold, input bit inject);
        correction_word_t expect_w;
        int               cycles;
        int               words;
        int               wait_cnt;
        @(posedge clk_i);
        req_i         <= 1'b1;
        grow_cycles_i <= GW'(g);
        cycles = 0;
        if (inject) begin
            @(posedge clk_i);
            meas_valid_i   <= 1'b1;  // Lands in a grow cycle
            measurements_i <= X'($random(seed));
            @(posedge clk_i);
            meas_valid_i <= 1'b0;
            cycles = 2;
        end
        do begin
            @(negedge clk_i);
            cycles++;
            if (cycles >= 2) begin
                assert (busy_o) else begin
                    errors++;
                    $display("FAILED at %0t: busy_o low during a run", $time);
                end
            end
        end while (!correction_valid_o && cycles < TIMEOUT);
        if (!correction_valid_o) stop_on_timeout("the first correction word");
        // The first negedge counts as one, and req_i is sampled one edge after that
        assert (cycles - 2 == g + 1) else begin
            errors++;
            $display("FAILED at %0t: first word %0d cycles after req, expected %0d",
                     $time, cycles - 2, g + 1);
        end
        words = 0;
        while (correction_valid_o && words < TIMEOUT) begin
            if (words < U) begin
                expect_w = expected_word(words, g);
                assert (correction_o === expect_w) else begin
                    errors++;
                    $display("FAILED at %0t: layer %0d word %h, expected %h",
                             $time, words, correction_o, expect_w);
                end
            end
            words++;
            @(negedge clk_i);
        end
        if (words >= TIMEOUT) stop_on_timeout("correction_valid_o to fall");
        assert (words == U) else begin
            errors++;
            $display("FAILED at %0t: %0d valid words, expected %0d", $time, words, U);
        end
        assert (ack_o) else begin
            errors++;
            $display("FAILED at %0t: ack_o not high one cycle after the last word", $time);
        end
        wait_cnt = 0;
        while (!ack_o && wait_cnt < TIMEOUT) begin
            @(negedge clk_i);
            wait_cnt++;
        end
        if (!ack_o) stop_on_timeout("ack_o to rise");
        repeat (hold) @(negedge clk_i);  // Protocol assertions watch ack_o here
        @(posedge clk_i);
        req_i <= 1'b0;
        wait_cnt = 0;
        do begin
            @(negedge clk_i);
            wait_cnt++;
        end while (ack_o && wait_cnt < TIMEOUT);
        if (ack_o) stop_on_timeout("ack_o to fall");
        assert (!busy_o) else begin
            errors++;
            $display("FAILED at %0t: busy_o still high after ack_o fell", $time);
        end
    endtask

    initial begin
        int g;
        reset_i        = 1'b1;
        meas_valid_i   = 1'b0;
        measurements_i = '0;
        req_i          = 1'b0;
        grow_cycles_i  = GW'(1);
        for (int k = 0; k < U; k++) begin
            rounds[k] = '0;
        end
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;

        @(negedge clk_i);
        assert (!ack_o && !busy_o && !correction_valid_o) else begin
            errors++;
            $display("FAILED at %0t: outputs not low after reset", $time);
        end
        for (int r = 0; r < U; r++) load_round('0);
        run_decode(1, 0, 1'b0);
        end_test("reset_and_zero_rounds");

        load_round('0);
        load_round('0);
        load_round(4'b0100);  // One flip in the newest round
        run_decode(1, 0, 1'b0);
        run_decode(2, 0, 1'b0);
        load_round(4'b0100);  // Repeating the round moves the defect one layer down
        run_decode(2, 0, 1'b0);
        end_test("single_defect");

        load_round('0);
        load_round('0);
        load_round(4'b0110);  // Defects share horizontal edge 2
        run_decode(1, 0, 1'b0);
        end_test("adjacent_defects");

        repeat (8) begin
            for (int r = 0; r < U; r++) load_round(X'($random(seed)));
            g = ($unsigned($random(seed)) % 7) + 1;
            run_decode(g, 0, 1'b0);
        end
        end_test("random_rounds");

        for (int r = 0; r < U; r++) load_round(X'($random(seed)));
        g = ($unsigned($random(seed)) % 7) + 1;
        run_decode(g, 3, 1'b1);
        run_decode(g, 0, 1'b0);  // Same rounds despite the pulse
        end_test("handshake");

        finish_run();
    end

endmodule

/* flist.f */
+incdir+hw
hw/decoding_graph_pkg.sv
hw/stage_controller.sv
hw/edge_link.sv
hw/graph_layer.sv
hw/decoding_graph_top.sv
tests/tb_decoding_graph.sv

/* Bender.yml */
package:
  name: decoding_graph

sources:
  - include_dirs:
      - hw
    files:
      - hw/decoding_graph_pkg.sv
      - hw/stage_controller.sv
      - hw/edge_link.sv
      - hw/graph_layer.sv
      - hw/decoding_graph_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_decoding_graph.sv
